// ==== hw/mem_pkg.sv ====
package mem_pkg;

  // bus widths
  localparam int ADDR_W = 32;
  localparam int DATA_W = 32;
  localparam int RESP_W = 2;

  typedef logic [ADDR_W-1:0] addr_t;  // byte address
  typedef logic [DATA_W-1:0] data_t;
  typedef logic [RESP_W-1:0] resp_t;

  localparam resp_t RESP_OKAY   = 2'b00;
  localparam resp_t RESP_SLVERR = 2'b10;

  // on-chip ram geometry
  localparam int RAM_WORDS = 32;
  localparam int RAM_IDX_W = $clog2(RAM_WORDS);  // word index width

  // cycles from AR handshake to rvalid, must be at least 2
  localparam int RAM_LATENCY = 3;
  localparam int RAM_CNT_W   = $clog2(RAM_LATENCY);

  localparam string RAM_INIT_FILE = "mem_init.hex";

  // ram read fsm
  typedef enum logic [1:0] {
    st_idle,
    st_wait,
    st_respond
  } ram_state_t;

endpackage

// ==== hw/mem_read_arb.sv ====
`timescale 1ns/1ps

module mem_read_arb import mem_pkg::*; (
  input  logic  clk,
  input  logic  rstn,
  // instruction fetch port
  input  logic  ifu_arvalid,
  output logic  ifu_arready,
  input  addr_t ifu_araddr,
  output logic  ifu_rvalid,
  input  logic  ifu_rready,
  output data_t ifu_rdata,
  output resp_t ifu_rresp,
  // load/store port
  input  logic  lsu_arvalid,
  output logic  lsu_arready,
  input  addr_t lsu_araddr,
  output logic  lsu_rvalid,
  input  logic  lsu_rready,
  output data_t lsu_rdata,
  output resp_t lsu_rresp,
  // ram side
  output logic  ram_arvalid,
  input  logic  ram_arready,
  output addr_t ram_araddr,
  input  logic  ram_rvalid,
  output logic  ram_rready,
  input  data_t ram_rdata,
  input  resp_t ram_rresp
);

  logic  ifu_buf_vld, lsu_buf_vld;
  addr_t ifu_buf_addr, lsu_buf_addr;
  logic  ifu_ar_hs, lsu_ar_hs;
  logic  req_ifu, req_lsu;
  addr_t addr_ifu, addr_lsu;
  logic  grant_ifu, grant_lsu;
  logic  last_lsu;  // 1 when lsu got the last grant
  logic  ar_free, ar_fire;

  // owner queue, 0 = ifu, 1 = lsu
  logic       owner_q [2];
  logic       q_wr_ptr, q_rd_ptr;
  logic [1:0] q_cnt;
  logic       q_push, q_pop, q_head;

  logic  hold_vld, hold_owner;
  data_t hold_data;
  resp_t hold_resp;
  logic  src_vld, src_owner, owner_free, deliver, to_hold;
  data_t src_data;
  resp_t src_resp;

  assign ifu_arready = !ifu_buf_vld;
  assign lsu_arready = !lsu_buf_vld;
  assign ifu_ar_hs   = ifu_arvalid && ifu_arready;
  assign lsu_ar_hs   = lsu_arvalid && lsu_arready;

  // a buffered address or a fresh handshake, never both for one master
  assign req_ifu  = ifu_buf_vld || ifu_ar_hs;
  assign req_lsu  = lsu_buf_vld || lsu_ar_hs;
  assign addr_ifu = ifu_buf_vld ? ifu_buf_addr : ifu_araddr;
  assign addr_lsu = lsu_buf_vld ? lsu_buf_addr : lsu_araddr;

  assign grant_ifu = req_ifu && (!req_lsu || last_lsu);
  assign grant_lsu = req_lsu && !grant_ifu;

  // output slot empties this cycle and the owner queue has room
  assign ar_free = (!ram_arvalid || ram_arready) && (q_cnt < 2'd2 || q_pop);
  assign ar_fire = ar_free && (req_ifu || req_lsu);

  always_ff @(posedge clk) begin
    if (!rstn) begin
      ifu_buf_vld <= 1'b0;
      lsu_buf_vld <= 1'b0;
    end else begin
      if (ar_fire && grant_ifu)
        ifu_buf_vld <= 1'b0;
      else if (ifu_ar_hs)
        ifu_buf_vld <= 1'b1;  // lost arbitration or port busy
      if (ar_fire && grant_lsu)
        lsu_buf_vld <= 1'b0;
      else if (lsu_ar_hs)
        lsu_buf_vld <= 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (ifu_ar_hs)
      ifu_buf_addr <= ifu_araddr;
    if (lsu_ar_hs)
      lsu_buf_addr <= lsu_araddr;
    if (ar_fire)
      ram_araddr <= grant_ifu ? addr_ifu : addr_lsu;
  end

  always_ff @(posedge clk) begin
    if (!rstn) begin
      ram_arvalid <= 1'b0;
      last_lsu    <= 1'b0;
    end else if (ar_fire) begin
      ram_arvalid <= 1'b1;
      last_lsu    <= grant_lsu;
    end else if (ram_arready) begin
      ram_arvalid <= 1'b0;
    end
  end

  assign q_push = ar_fire;
  assign q_pop  = ram_rvalid && ram_rready;
  assign q_head = owner_q[q_rd_ptr];

  always_ff @(posedge clk) begin
    if (!rstn) begin
      q_wr_ptr <= 1'b0;
      q_rd_ptr <= 1'b0;
      q_cnt    <= 2'd0;
    end else begin
      if (q_push)
        q_wr_ptr <= !q_wr_ptr;
      if (q_pop)
        q_rd_ptr <= !q_rd_ptr;
      q_cnt <= q_cnt + 2'(q_push) - 2'(q_pop);
    end
  end

  always_ff @(posedge clk) begin
    if (q_push)
      owner_q[q_wr_ptr] <= grant_lsu;
  end

  // response source, holding register first since ram_rready is low then
  assign ram_rready = !hold_vld;
  assign src_vld    = hold_vld || ram_rvalid;
  assign src_owner  = hold_vld ? hold_owner : q_head;
  assign src_data   = hold_vld ? hold_data : ram_rdata;
  assign src_resp   = hold_vld ? hold_resp : ram_rresp;
  assign owner_free = src_owner ? !lsu_rvalid : !ifu_rvalid;
  assign deliver    = src_vld && owner_free;
  assign to_hold    = q_pop && !owner_free;

  always_ff @(posedge clk) begin
    if (!rstn) begin
      ifu_rvalid <= 1'b0;
      lsu_rvalid <= 1'b0;
      hold_vld   <= 1'b0;
    end else begin
      if (ifu_rvalid && ifu_rready)
        ifu_rvalid <= 1'b0;
      if (lsu_rvalid && lsu_rready)
        lsu_rvalid <= 1'b0;
      if (deliver && !src_owner)
        ifu_rvalid <= 1'b1;
      if (deliver && src_owner)
        lsu_rvalid <= 1'b1;
      if (to_hold)
        hold_vld <= 1'b1;
      else if (hold_vld && deliver)
        hold_vld <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (deliver && !src_owner) begin
      ifu_rdata <= src_data;
      ifu_rresp <= src_resp;
    end
    if (deliver && src_owner) begin
      lsu_rdata <= src_data;
      lsu_rresp <= src_resp;
    end
    if (to_hold) begin
      hold_data  <= ram_rdata;
      hold_resp  <= ram_rresp;
      hold_owner <= q_head;
    end
  end

  // at most two reads between forward and response
  a_owner_q_no_overflow: assert property (@(posedge clk) disable iff (!rstn)
    q_push && !q_pop |-> q_cnt < 2'd2);

  a_ram_ar_hold: assert property (@(posedge clk) disable iff (!rstn)
    ram_arvalid && !ram_arready |=> ram_arvalid && $stable(ram_araddr));

endmodule

// ==== hw/sram_rd_slave.sv ====
`timescale 1ns/1ps

module sram_rd_slave import mem_pkg::*; (
  input  logic  clk,
  input  logic  rstn,
  input  logic  arvalid,
  output logic  arready,
  input  addr_t araddr,
  output logic  rvalid,
  input  logic  rready,
  output data_t rdata,
  output resp_t rresp
);

  data_t mem [RAM_WORDS];

  ram_state_t           state;
  logic [RAM_CNT_W-1:0] lat_cnt;
  logic [RAM_IDX_W-1:0] rd_idx;
  logic                 rd_err;
  logic                 ar_hs;
  logic                 lat_done;

  initial begin
    $readmemh(RAM_INIT_FILE, mem);
  end

  assign arready  = (state == st_idle);
  assign rvalid   = (state == st_respond);
  assign ar_hs    = arvalid && arready;
  assign lat_done = (state == st_wait) && (lat_cnt == '0);

  always_ff @(posedge clk) begin
    if (!rstn) begin
      state   <= st_idle;
      lat_cnt <= '0;
    end else begin
      case (state)
        st_idle: begin
          if (ar_hs) begin
            state   <= st_wait;
            lat_cnt <= RAM_CNT_W'(RAM_LATENCY - 1);
          end
        end
        st_wait: begin
          if (lat_done)
            state <= st_respond;
          else
            lat_cnt <= lat_cnt - 1'b1;
        end
        st_respond: begin
          if (rready)
            state <= st_idle;
        end
        default: state <= st_idle;
      endcase
    end
  end

  // address latched at the handshake, range checked on the byte address
  always_ff @(posedge clk) begin
    if (ar_hs) begin
      rd_idx <= araddr[RAM_IDX_W+1:2];
      rd_err <= araddr >= addr_t'(RAM_WORDS * 4);
    end
  end

  always_ff @(posedge clk) begin
    if (lat_done) begin
      if (rd_err) begin
        rdata <= '0;
        rresp <= RESP_SLVERR;
      end else begin
        rdata <= mem[rd_idx];
        rresp <= RESP_OKAY;
      end
    end
  end

  a_rdata_stable: assert property (@(posedge clk) disable iff (!rstn)
    rvalid && !rready |=> rvalid && $stable(rdata) && $stable(rresp));

endmodule

// ==== hw/mem_subsys_top.sv ====
`timescale 1ns/1ps

module mem_subsys_top import mem_pkg::*; (
  input  logic  clk,
  input  logic  rstn,
  input  logic  ifu_arvalid,
  output logic  ifu_arready,
  input  addr_t ifu_araddr,
  output logic  ifu_rvalid,
  input  logic  ifu_rready,
  output data_t ifu_rdata,
  output resp_t ifu_rresp,
  input  logic  lsu_arvalid,
  output logic  lsu_arready,
  input  addr_t lsu_araddr,
  output logic  lsu_rvalid,
  input  logic  lsu_rready,
  output data_t lsu_rdata,
  output resp_t lsu_rresp
);

  // arbiter to ram
  logic  ram_arvalid, ram_arready;
  addr_t ram_araddr;
  logic  ram_rvalid, ram_rready;
  data_t ram_rdata;
  resp_t ram_rresp;

  mem_read_arb i_arb (
    .clk, .rstn,
    .ifu_arvalid, .ifu_arready, .ifu_araddr,
    .ifu_rvalid, .ifu_rready, .ifu_rdata, .ifu_rresp,
    .lsu_arvalid, .lsu_arready, .lsu_araddr,
    .lsu_rvalid, .lsu_rready, .lsu_rdata, .lsu_rresp,
    .ram_arvalid, .ram_arready, .ram_araddr,
    .ram_rvalid, .ram_rready, .ram_rdata, .ram_rresp
  );

  sram_rd_slave i_ram (
    .clk, .rstn,
    .arvalid (ram_arvalid),
    .arready (ram_arready),
    .araddr  (ram_araddr),
    .rvalid  (ram_rvalid),
    .rready  (ram_rready),
    .rdata   (ram_rdata),
    .rresp   (ram_rresp)
  );

endmodule

// ==== verif/tb_mem_subsys.sv ====
`timescale 1ns/1ps

module tb_mem_subsys import mem_pkg::*; ();

  localparam int N_P1 = 40;   // ifu only
  localparam int N_P2 = 60;   // both masters back to back
  localparam int N_P3 = 120;  // gaps, rready stalls, bad addresses
  localparam int N_IFU = N_P1 + N_P2 + N_P3;
  localparam int N_LSU = N_P2 + N_P3;
  localparam int TIMEOUT_NS = (N_IFU + N_LSU) * 20 * 4;
  localparam logic [31:0] LFSR_TAPS = 32'h80200003;

  logic  clk, rstn;
  logic  ifu_arvalid, ifu_arready, ifu_rvalid, ifu_rready;
  logic  lsu_arvalid, lsu_arready, lsu_rvalid, lsu_rready;
  addr_t ifu_araddr, lsu_araddr;
  data_t ifu_rdata, lsu_rdata;
  resp_t ifu_rresp, lsu_rresp;

  // reference model with one expected entry per accepted address
  data_t model_mem [RAM_WORDS];
  data_t ifu_exp_data [N_IFU];
  resp_t ifu_exp_resp [N_IFU];
  data_t lsu_exp_data [N_LSU];
  resp_t lsu_exp_resp [N_LSU];
  int ifu_acnt = 0, ifu_rcnt = 0, lsu_acnt = 0, lsu_rcnt = 0;
  int ifu_left = 0, lsu_left = 0;  // requests still to issue in the phase
  int data_errs = 0, proto_errs = 0, count_errs = 0;
  logic [31:0] lfsr;

  mem_subsys_top i_mem_subsys_top (.*);

  always #2 clk = ~clk;

  // galois lfsr stepped once per bit
  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      v = {v[30:0], lfsr[0]};
      lfsr = lfsr[0] ? (lfsr >> 1) ^ LFSR_TAPS : lfsr >> 1;
    end
    return v;
  endfunction

  function automatic addr_t pick_addr(input bit errs);
    logic [31:0] sel;
    sel = errs ? rand_bits(3) : 32'd7;
    if (sel == 0)
      return addr_t'(RAM_WORDS * 4) + (rand_bits(12) << 2);  // past the end
    if (sel == 1)
      return addr_t'(RAM_WORDS * 4);  // first bad word
    return rand_bits(5) << 2;
  endfunction

  task automatic record_ar(input bit lsu, input addr_t a);
    data_t d;
    resp_t r;
    d = (a >= addr_t'(RAM_WORDS * 4)) ? '0 : model_mem[a[6:2]];
    r = (a >= addr_t'(RAM_WORDS * 4)) ? RESP_SLVERR : RESP_OKAY;
    if (lsu) begin
      lsu_exp_data[lsu_acnt] <= d;
      lsu_exp_resp[lsu_acnt] <= r;
      lsu_acnt <= lsu_acnt + 1;
    end else begin
      ifu_exp_data[ifu_acnt] <= d;
      ifu_exp_resp[ifu_acnt] <= r;
      ifu_acnt <= ifu_acnt + 1;
    end
  endtask

  task automatic tick(input bit gaps, input bit stalls, input bit errs);
    @(posedge clk);
    if (ifu_arvalid && ifu_arready)
      record_ar(1'b0, ifu_araddr);
    if (lsu_arvalid && lsu_arready)
      record_ar(1'b1, lsu_araddr);
    if (ifu_rvalid && ifu_rready)
      ifu_rcnt <= ifu_rcnt + 1;
    if (lsu_rvalid && lsu_rready)
      lsu_rcnt <= lsu_rcnt + 1;
    if (!ifu_arvalid || ifu_arready) begin  // free to change the address
      if (ifu_left > 0 && (!gaps || rand_bits(2) != 0)) begin
        ifu_arvalid <= 1'b1;
        ifu_araddr  <= pick_addr(errs);
        ifu_left = ifu_left - 1;
      end else begin
        ifu_arvalid <= 1'b0;
      end
    end
    if (!lsu_arvalid || lsu_arready) begin
      if (lsu_left > 0 && (!gaps || rand_bits(2) != 0)) begin
        lsu_arvalid <= 1'b1;
        lsu_araddr  <= pick_addr(errs);
        lsu_left = lsu_left - 1;
      end else begin
        lsu_arvalid <= 1'b0;
      end
    end
    ifu_rready <= stalls ? (rand_bits(1) != 0) : 1'b1;
    lsu_rready <= stalls ? (rand_bits(2) != 0) : 1'b1;
  endtask

  // runs until every issued request has its response
  task automatic run_phase(input int n_ifu, input int n_lsu, input bit gaps,
                           input bit stalls, input bit errs);
    ifu_left = n_ifu;
    lsu_left = n_lsu;
    do
      tick(gaps, stalls, errs);
    while (ifu_left > 0 || lsu_left > 0 || ifu_arvalid || lsu_arvalid ||
           ifu_rcnt != ifu_acnt || lsu_rcnt != lsu_acnt);
  endtask

  a_reset_idle: assert property (@(posedge clk)
    $rose(rstn) |-> !ifu_rvalid && !lsu_rvalid && ifu_arready && lsu_arready)
    else begin
      proto_errs++;
      $display("ports are not idle when reset is released");
    end

  a_ifu_resp: assert property (@(posedge clk) disable iff (!rstn)
    ifu_rvalid && ifu_rready && ifu_rcnt < ifu_acnt |->
      ifu_rdata == ifu_exp_data[ifu_rcnt] && ifu_rresp == ifu_exp_resp[ifu_rcnt])
    else begin
      data_errs++;
      $display("[ERROR] ifu_rdata %h ifu_rresp %h, expected %h %h", $sampled(ifu_rdata),
        $sampled(ifu_rresp), ifu_exp_data[$sampled(ifu_rcnt)], ifu_exp_resp[$sampled(ifu_rcnt)]);
    end

  a_lsu_resp: assert property (@(posedge clk) disable iff (!rstn)
    lsu_rvalid && lsu_rready && lsu_rcnt < lsu_acnt |->
      lsu_rdata == lsu_exp_data[lsu_rcnt] && lsu_rresp == lsu_exp_resp[lsu_rcnt])
    else begin
      data_errs++;
      $display("[ERROR] lsu_rdata %h lsu_rresp %h, expected %h %h", $sampled(lsu_rdata),
        $sampled(lsu_rresp), lsu_exp_data[$sampled(lsu_rcnt)], lsu_exp_resp[$sampled(lsu_rcnt)]);
    end

  a_ifu_no_extra: assert property (@(posedge clk) disable iff (!rstn)
    ifu_rvalid && ifu_rready |-> ifu_rcnt < ifu_acnt)
    else begin
      proto_errs++;
      $display("ifu got a response with no request outstanding");
    end

  a_lsu_no_extra: assert property (@(posedge clk) disable iff (!rstn)
    lsu_rvalid && lsu_rready |-> lsu_rcnt < lsu_acnt)
    else begin
      proto_errs++;
      $display("lsu got a response with no request outstanding");
    end

  a_ifu_stall: assert property (@(posedge clk) disable iff (!rstn)
    ifu_rvalid && !ifu_rready |=> ifu_rvalid && $stable(ifu_rdata) && $stable(ifu_rresp))
    else begin
      proto_errs++;
      $display("ifu response dropped or changed while stalled");
    end

  a_lsu_stall: assert property (@(posedge clk) disable iff (!rstn)
    lsu_rvalid && !lsu_rready |=> lsu_rvalid && $stable(lsu_rdata) && $stable(lsu_rresp))
    else begin
      proto_errs++;
      $display("lsu response dropped or changed while stalled");
    end

  initial begin
    #(TIMEOUT_NS * 1ns);
    $display("timeout after %0d ns with responses still missing", TIMEOUT_NS);
    $display("SIMULATION FAILED");
    $finish;
  end

  initial begin
    clk = 1'b0;
    rstn = 1'b0;
    ifu_arvalid = 1'b0;
    ifu_araddr = '0;
    ifu_rready = 1'b1;
    lsu_arvalid = 1'b0;
    lsu_araddr = '0;
    lsu_rready = 1'b1;
    lfsr = 32'h57bd3691;
    $readmemh(RAM_INIT_FILE, model_mem);
    repeat (4) @(posedge clk);
    rstn <= 1'b1;
    run_phase(N_P1, 0, 1'b0, 1'b0, 1'b0);
    run_phase(N_P2, N_P2, 1'b0, 1'b0, 1'b0);
    run_phase(N_P3, N_P3, 1'b1, 1'b1, 1'b1);
    // drain with rready high so a late extra response still gets counted
    repeat (4 * RAM_LATENCY) tick(1'b0, 1'b0, 1'b0);
    @(posedge clk);
    assert (ifu_rcnt == N_IFU && ifu_acnt == N_IFU)
      else begin
        count_errs++;
        $display("[ERROR] ifu_rvalid handshakes %h, expected %h", ifu_rcnt, N_IFU);
      end
    assert (lsu_rcnt == N_LSU && lsu_acnt == N_LSU)
      else begin
        count_errs++;
        $display("[ERROR] lsu_rvalid handshakes %h, expected %h", lsu_rcnt, N_LSU);
      end
    $display("errors: %0d data, %0d protocol, %0d count", data_errs, proto_errs, count_errs);
    if (data_errs + proto_errs + count_errs == 0)
      $display("SIMULATION PASSED");
    else
      $display("SIMULATION FAILED");
    $finish;
  end

endmodule

// ==== list.f ====
hw/mem_pkg.sv
hw/mem_read_arb.sv
hw/sram_rd_slave.sv
hw/mem_subsys_top.sv
verif/tb_mem_subsys.sv

// ==== Makefile ====
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -Wno-fatal -j 0
TOP       := tb_mem_subsys
FILELIST  := list.f
OBJ_DIR   := obj_dir
MEMFILE   := mem_init.hex

SIM  := $(OBJ_DIR)/V$(TOP)
SRCS := $(shell grep -v '^+' $(FILELIST))

.PHONY: all run clean

all: run

$(SIM): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# output is shown, the exit status comes from the pass line
run: $(SIM) $(MEMFILE)
	@out="$$(./$(SIM))"; echo "$$out"; echo "$$out" | grep -qx "SIMULATION PASSED"

clean:
	rm -rf $(OBJ_DIR)

// ==== mem_init.hex ====
// one 32-bit word per line, word 0 first
00FFA53C
01FEA43D
02FDA73E
03FCA63F
04FBA140
05FAA041
06F9A342
07F8A243
08F7AD44
09F6AC45
0AF5AF46
0BF4AE47
0CF3A948
0DF2A849
0EF1AB4A
0FF0AA4B
10EFB54C
11EEB44D
12EDB74E
13ECB64F
14EBB150
15EAB051
16E9B352
17E8B253
18E7BD54
19E6BC55
1AE5BF56
1BE4BE57
1CE3B958
1DE2B859
1EE1BB5A
1FE0BA5B
